/* vlog.f */
+incdir+include
hdl/lpif_pkg.sv
hdl/link_auto_sync.sv
hdl/lpif_field_pack.sv
hdl/link_phy_concat.sv
hdl/lpif_link_top.sv
tests/tb_lpif_link.sv

/* Makefile */
# Verilator flow for the LPIF link testbench
# Override any variable on the command line, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= tb_lpif_link
FLIST     ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
FAIL_MSG  ?= Test failed

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv tests/*.sv include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

# Log is searched for the fail message; a crash also counts as failure
run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation reported a failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/lpif_tb_vectors.svh */
`ifndef LPIF_TB_VECTORS_SVH
`define LPIF_TB_VECTORS_SVH

// Row fields are tx_online, rx_online, delay_x, delay_y, delay_z, cycles in the row,
// the flit template with LFSR data and the strobe words expected in the row

typedef struct packed {
  logic                   tx_on;
  logic                   rx_on;
  logic [DELAY_WIDTH-1:0] dx;
  logic [DELAY_WIDTH-1:0] dy;
  logic [DELAY_WIDTH-1:0] dz;
  logic [7:0]             cycles;
  lpif_flit_t             flit;
  logic [7:0]             exp_stb;
} vec_row_t;

localparam int NUM_ROWS = 13;

localparam vec_row_t VEC_TABLE [NUM_ROWS] = '{
  // Valid flits must not leak while offline
  '{1'b0, 1'b0, 16'd7, 16'd0, 16'd3, 8'd4,
    '{LPIF_RESET, 2'd0, 64'd0, 1'b1, 2'd0, 1'b0, 1'b1}, 8'd0},
  // Both up with TX after 3 and RX after 7 and a persistent strobe
  '{1'b1, 1'b1, 16'd7, 16'd0, 16'd3, 8'd12,
    '{LPIF_ACTIVE, 2'd1, 64'd0, 1'b1, 2'd2, 1'b1, 1'b1}, 8'd8},
  '{1'b1, 1'b1, 16'd7, 16'd0, 16'd3, 8'd10,
    '{LPIF_RETRAIN, 2'd2, 64'd0, 1'b0, 2'd1, 1'b1, 1'b1}, 8'd10},
  // TX drops and the last word is still strobed
  '{1'b0, 1'b1, 16'd7, 16'd0, 16'd3, 8'd4,
    '{LPIF_ACTIVE, 2'd3, 64'd0, 1'b1, 2'd3, 1'b0, 1'b1}, 8'd1},
  // Drain with new delays
  '{1'b0, 1'b0, 16'd2, 16'd2, 16'd5, 8'd3,
    '{LPIF_LINK_ERROR, 2'd0, 64'd0, 1'b0, 2'd0, 1'b0, 1'b1}, 8'd0},
  // RX ready early while data waits on the TX path
  '{1'b1, 1'b1, 16'd2, 16'd2, 16'd5, 8'd16,
    '{LPIF_ACTIVE, 2'd1, 64'd0, 1'b1, 2'd1, 1'b1, 1'b1}, 8'd4},
  '{1'b1, 1'b1, 16'd2, 16'd2, 16'd5, 8'd8,
    '{LPIF_PMNAK, 2'd2, 64'd0, 1'b1, 2'd2, 1'b0, 1'b1}, 8'd2},
  '{1'b0, 1'b1, 16'd2, 16'd2, 16'd5, 8'd3,
    '{LPIF_L1, 2'd3, 64'd0, 1'b0, 2'd1, 1'b1, 1'b1}, 8'd1},
  // TX back up after the full delay again
  '{1'b1, 1'b1, 16'd2, 16'd2, 16'd5, 8'd10,
    '{LPIF_L2, 2'd0, 64'd0, 1'b1, 2'd3, 1'b1, 1'b1}, 8'd2},
  '{1'b1, 1'b1, 16'd2, 16'd2, 16'd5, 8'd6,
    '{LPIF_LINK_RESET, 2'd1, 64'd0, 1'b1, 2'd2, 1'b1, 1'b1}, 8'd2},
  '{1'b0, 1'b0, 16'd2, 16'd2, 16'd5, 8'd6,
    '{LPIF_DISABLED, 2'd2, 64'd0, 1'b0, 2'd0, 1'b0, 1'b1}, 8'd0},
  // Zero delays and a strobe every other word
  '{1'b1, 1'b1, 16'd0, 16'd1, 16'd0, 8'd8,
    '{LPIF_ACTIVE, 2'd3, 64'd0, 1'b1, 2'd3, 1'b1, 1'b1}, 8'd4},
  '{1'b0, 1'b0, 16'd0, 16'd1, 16'd0, 8'd6,
    '{LPIF_RESET, 2'd0, 64'd0, 1'b0, 2'd0, 1'b0, 1'b0}, 8'd0}
};

`endif

/* tests/tb_lpif_link.sv */
`timescale 1ns/100ps

module tb_lpif_link import lpif_pkg::*; ();

  localparam int RESET_CYCLES = 16;

  logic                   clk_wr;
  logic                   reset;
  logic                   tx_online;
  logic                   rx_online;
  logic [DELAY_WIDTH-1:0] delay_x_value;
  logic [DELAY_WIDTH-1:0] delay_y_value;
  logic [DELAY_WIDTH-1:0] delay_z_value;
  lpif_flit_t             dstrm;
  lpif_flit_t             ustrm;
  phy_word_t              rx_phy0;
  phy_word_t              tx_phy0;

  `include "lpif_tb_vectors.svh"

  // Scoreboard with tx_flit at index 0 and ustrm at index 3
  lpif_flit_t  pipe_q [$];
  phy_word_t   exp_phy;
  logic        exp_tx_dly;
  logic        exp_rx_dly;
  int          tx_high;
  int          rx_high;
  int          word_idx;
  // Latency bookkeeping
  logic        tx_wait;
  logic        rx_wait;
  int          tx_rise_cyc;
  int          rx_rise_cyc;
  int          tx_first_cyc;
  int          now_cyc;
  int          stb_seen;
  // Error counts and watchdog
  int          mismatch_cnt;
  int          other_cnt;
  int          cycle_limit;
  int          wd_cycles;
  logic [15:0] lfsr_q;

  lpif_link_top i_lpif_link_top (
    .clk_wr        (clk_wr),
    .reset         (reset),
    .tx_online     (tx_online),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .delay_y_value (delay_y_value),
    .delay_z_value (delay_z_value),
    .dstrm         (dstrm),
    .ustrm         (ustrm),
    .rx_phy0       (rx_phy0),
    .tx_phy0       (tx_phy0)
  );

  // External loopback held at zero in reset
  assign rx_phy0 = reset ? '0 : tx_phy0;

  initial begin
    clk_wr = 1'b0;
    forever #20 clk_wr = ~clk_wr;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // One LFSR step per data bit
  task automatic random_data(output logic [63:0] d);
    d = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      d = {d[62:0], lfsr_q[0]};
    end
  endtask

  function automatic int run_limit();
    int total;
    total = RESET_CYCLES + 50;
    for (int r = 0; r < NUM_ROWS; r++) begin
      total += int'(VEC_TABLE[r].cycles);
      total += int'(VEC_TABLE[r].dx) + int'(VEC_TABLE[r].dy) + int'(VEC_TABLE[r].dz);
    end
    return 2 * total;
  endfunction

  task automatic check_flit(input string name, input lpif_flit_t exp_val,
                            input lpif_flit_t act_val);
    if (act_val !== exp_val) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_phy(input string name, input phy_word_t exp_val,
                           input phy_word_t act_val);
    if (act_val !== exp_val) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, exp_val, act_val);
    end
  endtask

  task automatic check_count(input string name, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s expected %0d got %0d", $time, name, exp_val, act_val);
    end
  endtask

  //////////////////////////////////////////////////
  // Reference model and checks
  //////////////////////////////////////////////////

  // Advance by one edge with the inputs that edge sampled
  task automatic model_step();
    int period;
    period = int'(delay_y_value) + 1;
    if (exp_tx_dly) begin
      exp_phy.spare  = '0;
      exp_phy.flit   = pipe_q[0];
      exp_phy.marker = 2'b00;
      exp_phy.strobe = (word_idx % period) == 0;
      word_idx++;
    end else begin
      // Idle PHY word drops the flit
      exp_phy   = '0;
      word_idx  = 0;
      pipe_q[0] = '0;
    end
    if (!exp_rx_dly) begin
      pipe_q[2] = '0;
    end
    void'(pipe_q.pop_back());
    pipe_q.push_front(dstrm);
    // Count edges that saw the input high
    tx_high    = tx_online ? tx_high + 1 : 0;
    rx_high    = rx_online ? rx_high + 1 : 0;
    exp_tx_dly = tx_high > int'(delay_z_value);
    exp_rx_dly = rx_high > int'(delay_x_value);
  endtask

  task automatic check_outputs();
    int exp_lat;
    check_phy("tx_phy0", exp_phy, tx_phy0);
    check_flit("ustrm", pipe_q[3], ustrm);
    if (tx_phy0.strobe) begin
      stb_seen++;
    end
    if (tx_wait && tx_phy0 != '0) begin
      check_count("tx_phy0 latency", int'(delay_z_value) + 2, now_cyc - tx_rise_cyc);
      tx_wait = 1'b0;
    end
    // RX side also waits for the first word through the TX path
    if (rx_wait && ustrm != '0) begin
      exp_lat = int'(delay_x_value) + 2;
      if (tx_first_cyc + 2 - rx_rise_cyc > exp_lat) begin
        exp_lat = tx_first_cyc + 2 - rx_rise_cyc;
      end
      check_count("ustrm latency", exp_lat, now_cyc - rx_rise_cyc);
      rx_wait = 1'b0;
    end
  endtask

  task automatic drive_row(input vec_row_t row);
    lpif_flit_t  flit;
    logic [63:0] data;
    if (row.tx_on && !tx_online) begin
      tx_wait      = 1'b1;
      tx_rise_cyc  = now_cyc;
      // First TX word lands after the Z delay and two registers
      tx_first_cyc = now_cyc + int'(row.dz) + 2;
    end
    if (row.rx_on && !rx_online) begin
      rx_wait     = 1'b1;
      rx_rise_cyc = now_cyc;
    end
    random_data(data);
    flit          = row.flit;
    flit.data     = data;
    tx_online     = row.tx_on;
    rx_online     = row.rx_on;
    delay_x_value = row.dx;
    delay_y_value = row.dy;
    delay_z_value = row.dz;
    dstrm         = flit;
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    reset         = 1'b1;
    tx_online     = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = '0;
    delay_y_value = '0;
    delay_z_value = '0;
    dstrm         = '0;
    lfsr_q        = 16'd49392;
    exp_phy       = '0;
    exp_tx_dly    = 1'b0;
    exp_rx_dly    = 1'b0;
    tx_high       = 0;
    rx_high       = 0;
    word_idx      = 0;
    tx_wait       = 1'b0;
    rx_wait       = 1'b0;
    tx_rise_cyc   = 0;
    rx_rise_cyc   = 0;
    tx_first_cyc  = 0;
    now_cyc       = 0;
    mismatch_cnt  = 0;
    other_cnt     = 0;
    repeat (4) pipe_q.push_back('0);

    repeat (RESET_CYCLES) @(posedge clk_wr);
    @(negedge clk_wr);
    check_phy("tx_phy0 in reset", '0, tx_phy0);
    check_flit("ustrm in reset", '0, ustrm);
    reset = 1'b0;

    for (int r = 0; r < NUM_ROWS; r++) begin
      stb_seen = 0;
      for (int c = 0; c < int'(VEC_TABLE[r].cycles); c++) begin
        drive_row(VEC_TABLE[r]);
        @(posedge clk_wr);
        @(negedge clk_wr);
        now_cyc++;
        model_step();
        check_outputs();
      end
      check_count($sformatf("row %0d strobe words", r), int'(VEC_TABLE[r].exp_stb), stb_seen);
    end

    if (tx_wait || rx_wait) begin
      other_cnt++;
      $display("an online output never came up after its online input was raised");
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog on the clock
  initial begin
    wd_cycles   = 0;
    cycle_limit = run_limit();
    while (wd_cycles < cycle_limit) begin
      @(posedge clk_wr);
      wd_cycles++;
    end
    $display("timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Test failed");
    $finish;
  end

endmodule

/* hdl/lpif_link_top.sv */
`timescale 1ns/100ps

module lpif_link_top import lpif_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   reset,

  // Online control
  input  logic                   tx_online,
  input  logic                   rx_online,

  // Delay settings, static while online
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_y_value,
  input  logic [DELAY_WIDTH-1:0] delay_z_value,

  // User side
  input  lpif_flit_t             dstrm,
  output lpif_flit_t             ustrm,

  // PHY side
  input  phy_word_t              rx_phy0,
  output phy_word_t              tx_phy0
);

  //////////////////////////////////////////////////
  // Internal wires
  //////////////////////////////////////////////////

  logic       tx_online_delay;
  logic       rx_online_delay;
  logic       stb_userbit;
  // Flits between packer and concatenator
  lpif_flit_t tx_flit;
  lpif_flit_t rx_flit;

  //////////////////////////////////////////////////
  // Auto sync
  //////////////////////////////////////////////////

  link_auto_sync i_link_auto_sync (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .stb_userbit     (stb_userbit)
  );

  //////////////////////////////////////////////////
  // User field packer
  //////////////////////////////////////////////////

  // FIFO and credit logic bypassed, flits go straight through
  lpif_field_pack i_lpif_field_pack (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .rx_online_delay (rx_online_delay),
    .dstrm           (dstrm),
    .rx_flit         (rx_flit),
    .tx_flit         (tx_flit),
    .ustrm           (ustrm)
  );

  //////////////////////////////////////////////////
  // PHY concatenation
  //////////////////////////////////////////////////

  link_phy_concat i_link_phy_concat (
    .clk_wr          (clk_wr),
    .reset           (reset),
    .tx_online_delay (tx_online_delay),
    .stb_userbit     (stb_userbit),
    .tx_flit         (tx_flit),
    .rx_phy0         (rx_phy0),
    .tx_phy0         (tx_phy0),
    .rx_flit         (rx_flit)
  );

endmodule

/* hdl/link_phy_concat.sv */
`timescale 1ns/100ps

module link_phy_concat import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       reset,
  input  logic       tx_online_delay,
  input  logic       stb_userbit,
  input  lpif_flit_t tx_flit,
  input  phy_word_t  rx_phy0,
  output phy_word_t  tx_phy0,
  output lpif_flit_t rx_flit
);

  // Next TX PHY word
  phy_word_t tx_word;

  //////////////////////////////////////////////////
  // TX concatenation
  //////////////////////////////////////////////////

  // Flit sits between marker and spare bits
  always_comb begin
    tx_word.spare  = '0;
    tx_word.flit   = tx_flit;
    // No marker generation on this channel
    tx_word.marker = NO_MARKER_VALUE;
    tx_word.strobe = stb_userbit;
  end

  always_ff @(posedge clk_wr) begin
    // Idle word while TX is offline
    if (reset || !tx_online_delay) begin
      tx_phy0 <= '0;
    end else begin
      tx_phy0 <= tx_word;
    end
  end

  //////////////////////////////////////////////////
  // RX extraction
  //////////////////////////////////////////////////

  // Strobe, marker and spare dropped here
  always_ff @(posedge clk_wr) begin
    rx_flit <= rx_phy0.flit;
    // Qualifiers cleared in reset
    if (reset) begin
      rx_flit.dvalid    <= 1'b0;
      rx_flit.crc_valid <= 1'b0;
      rx_flit.valid     <= 1'b0;
    end
  end

endmodule

/* hdl/lpif_field_pack.sv */
`timescale 1ns/100ps

module lpif_field_pack import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       reset,
  input  logic       rx_online_delay,
  input  lpif_flit_t dstrm,
  input  lpif_flit_t rx_flit,
  output lpif_flit_t tx_flit,
  output lpif_flit_t ustrm
);

  //////////////////////////////////////////////////
  // TX packing
  //////////////////////////////////////////////////

  // Downstream fields into the flit once per cycle
  always_ff @(posedge clk_wr) begin
    // Payload fields
    tx_flit.state     <= dstrm.state;
    tx_flit.protid    <= dstrm.protid;
    tx_flit.data      <= dstrm.data;
    tx_flit.crc       <= dstrm.crc;
    // Qualifiers
    tx_flit.dvalid    <= dstrm.dvalid;
    tx_flit.crc_valid <= dstrm.crc_valid;
    tx_flit.valid     <= dstrm.valid;
    // No valid word leaves while in reset
    if (reset) begin
      tx_flit.dvalid    <= 1'b0;
      tx_flit.crc_valid <= 1'b0;
      tx_flit.valid     <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // RX unpacking
  //////////////////////////////////////////////////

  // Upstream register
  always_ff @(posedge clk_wr) begin
    // Nothing stale reaches the user before RX is online
    if (reset || !rx_online_delay) begin
      ustrm <= '0;
    end else begin
      ustrm <= rx_flit;
    end
  end

endmodule

/* hdl/link_auto_sync.sv */
`timescale 1ns/100ps

module link_auto_sync import lpif_pkg::*; (
  input  logic                   clk_wr,
  input  logic                   reset,
  input  logic                   tx_online,
  input  logic                   rx_online,
  input  logic [DELAY_WIDTH-1:0] delay_x_value,
  input  logic [DELAY_WIDTH-1:0] delay_y_value,
  input  logic [DELAY_WIDTH-1:0] delay_z_value,
  output logic                   tx_online_delay,
  output logic                   rx_online_delay,
  output logic                   stb_userbit
);

  // Index 0 is the TX flag, index 1 the RX flag
  logic                   online_in [2];
  logic [DELAY_WIDTH-1:0] delay_in  [2];
  sync_state_e            state_q   [2];
  logic [DELAY_WIDTH-1:0] cnt_q     [2];

  // Strobe spacing counter
  logic [DELAY_WIDTH-1:0] stb_cnt_q;

  //////////////////////////////////////////////////
  // Online delay machines
  //////////////////////////////////////////////////

  // TX waits delay_z, RX waits delay_x
  assign online_in[0] = tx_online;
  assign online_in[1] = rx_online;
  assign delay_in[0]  = delay_z_value;
  assign delay_in[1]  = delay_x_value;

  always_ff @(posedge clk_wr) begin
    for (int i = 0; i < 2; i++) begin
      // Dropping the input restarts the whole delay
      if (reset || !online_in[i]) begin
        state_q[i] <= SYNC_OFFLINE;
        cnt_q[i]   <= '0;
      end else begin
        case (state_q[i])
          SYNC_OFFLINE: begin
            // Zero delay goes online on the sampling edge
            if (delay_in[i] == '0) begin
              state_q[i] <= SYNC_ONLINE;
            end else begin
              state_q[i] <= SYNC_COUNTING;
              // First edge already counts as one
              cnt_q[i]   <= delay_in[i] - DELAY_WIDTH'(1);
            end
          end
          SYNC_COUNTING: begin
            if (cnt_q[i] == '0) begin
              state_q[i] <= SYNC_ONLINE;
            end else begin
              cnt_q[i] <= cnt_q[i] - DELAY_WIDTH'(1);
            end
          end
          default: begin
            // Stay online until input drops
            state_q[i] <= SYNC_ONLINE;
          end
        endcase
      end
    end
  end

  // Flags straight off the state registers
  assign tx_online_delay = (state_q[0] == SYNC_ONLINE);
  assign rx_online_delay = (state_q[1] == SYNC_ONLINE);

  //////////////////////////////////////////////////
  // Strobe user bit
  //////////////////////////////////////////////////

  // Zero while offline, so the first online word strobes
  always_ff @(posedge clk_wr) begin
    if (reset || !tx_online_delay) begin
      stb_cnt_q <= '0;
    end else if (stb_cnt_q == '0) begin
      stb_cnt_q <= delay_y_value;
    end else begin
      stb_cnt_q <= stb_cnt_q - DELAY_WIDTH'(1);
    end
  end

  // delay_y of zero keeps the counter at zero, a persistent strobe
  assign stb_userbit = tx_online_delay && (stb_cnt_q == '0);

endmodule

/* hdl/lpif_pkg.sv */
package lpif_pkg;

  //////////////////////////////////////////////////
  // Layout constants
  //////////////////////////////////////////////////

  // Full PHY word for one x1 half-rate channel
  localparam int PHY_WIDTH = 80;

  // Flit carried inside the PHY word
  localparam int FLIT_WIDTH = 75;

  // Marker field, always zero here
  localparam logic [1:0] NO_MARKER_VALUE = 2'b00;

  // Width of the online and strobe delay settings
  localparam int DELAY_WIDTH = 16;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // LPIF link state as carried in the flit
  typedef enum logic [3:0] {
    LPIF_RESET      = 4'b0000,
    LPIF_ACTIVE     = 4'b0001,
    LPIF_PMNAK      = 4'b0011,
    LPIF_L1         = 4'b0100,
    LPIF_L2         = 4'b1000,
    LPIF_LINK_RESET = 4'b1001,
    LPIF_LINK_ERROR = 4'b1010,
    LPIF_RETRAIN    = 4'b1011,
    LPIF_DISABLED   = 4'b1100
  } lpif_state_e;

  // Auto-sync phase per online flag
  typedef enum logic [1:0] {
    SYNC_OFFLINE  = 2'b00,
    SYNC_COUNTING = 2'b01,
    SYNC_ONLINE   = 2'b10
  } sync_state_e;

  //////////////////////////////////////////////////
  // Packed words
  //////////////////////////////////////////////////

  // Flit, MSB first
  typedef struct packed {
    lpif_state_e state;
    logic [1:0]  protid;
    logic [63:0] data;
    logic        dvalid;
    logic [1:0]  crc;
    logic        crc_valid;
    logic        valid;
  } lpif_flit_t;

  // PHY word, strobe lands on bit 0
  typedef struct packed {
    // Leftover bits above flit, marker and strobe
    logic [PHY_WIDTH-FLIT_WIDTH-4:0] spare;
    lpif_flit_t                      flit;
    logic [1:0]                      marker;
    logic                            strobe;
  } phy_word_t;

endpackage
